// File: Bender.yml
package:
  name: soc_ctrl

sources:
  - soc_ctrl_pkg.sv
  - pi_stage.sv
  - map_size_calc.sv
  - dev_table.sv
  - soc_ctrl_top.sv
  - target: test
    files:
      - tb_soc_ctrl.sv

// File: dev_table.sv
// Device table slave.
// Reads return per-slot IDs and map sizes; read-writes at word 0 run INFO
// queries and at word 1 run ACTION commands that drive the reset outputs.
`timescale 1ns/1ps
`default_nettype none

module dev_table (
	input  logic                                                    clk_i,
	input  logic                                                    rst_i,
	input  logic [1:0]                                              req_op_i,
	input  logic [soc_ctrl_pkg::DATA_W-1:0]                         req_byte_addr_i,
	input  logic [soc_ctrl_pkg::DATA_W-1:0]                         req_data_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT*soc_ctrl_pkg::DATA_W-1:0] dev_id_flat_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT*soc_ctrl_pkg::DATA_W-1:0] dev_mapsz_flat_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT-1:0]                    dev_useintr_i,
	input  logic [soc_ctrl_pkg::DATA_W-1:0]                         ram_map_sz_i,
	output logic [soc_ctrl_pkg::DATA_W-1:0]                         rd_data_o,
	output logic                                                    rst0_o,
	output logic                                                    rst1_o,
	output logic                                                    rst2_o
);

	import soc_ctrl_pkg::*;

	logic [DATA_W-3:0] word_idx;
	logic [DATA_W-4:0] slot;
	logic              is_rd;
	logic              is_rw;
	logic              is_action;
	logic              is_rreset;
	logic              relocated;
	logic [DATA_W-1:0] table_word;
	logic [DATA_W-1:0] info_word;
	map_word_u         map_word;

	assign word_idx = req_byte_addr_i[DATA_W-1:2];
	assign slot = word_idx[DATA_W-3:1];
	assign is_rd = (req_op_i == OP_RD);
	assign is_rw = (req_op_i == OP_RW);
	assign is_action = is_rw && (word_idx == 1);
	assign is_rreset = is_action && (req_data_i == ACT_RRESET);

	// Table entry of the addressed slot.
	always_comb begin
		map_word.raw = '0;
		table_word = '0;
		for (int i = 0; i < DEV_MAP_CNT; i++) begin
			if (slot == i) begin
				if (i == 0) begin
					map_word.pair.half_sz = BLOCK_MAP_SZ[DATA_W-1:1];
				end else if (i == 1) begin
					map_word.pair.half_sz = ram_map_sz_i[DATA_W-1:1];
				end else begin
					map_word.pair.half_sz = dev_mapsz_flat_i[i*DATA_W+1 +: DATA_W-1];
				end
				map_word.pair.intr = dev_useintr_i[i];
				table_word = word_idx[0] ? map_word.raw : dev_id_flat_i[i*DATA_W +: DATA_W];
			end
		end
	end

	// INFO query result.
	always_comb begin
		case (req_data_i)
			INFO_VERSION: info_word = SOC_VERSION;
			INFO_CACHE_SZ: info_word = RAM_CACHE_SZ;
			INFO_RST_STATE: info_word = {{(DATA_W - 2){1'b0}}, rst1_o, rst0_o};
			INFO_PRELDR: info_word = relocated ? '0 : PRELDR_ADDR; // Gone after relocation.
			INFO_SOC_ID: info_word = SOC_ID;
			default: info_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_data_o <= '0;
		end else if (is_rd) begin
			rd_data_o <= table_word; // Out-of-range slots give zero.
		end else if (is_rw) begin
			rd_data_o <= (word_idx == 0) ? info_word : '0;
		end
	end

	// Reset controls.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
			rst2_o <= 1'b0;
			relocated <= 1'b0;
		end else begin
			if (is_action) begin
				case (req_data_i)
					ACT_PWROFF: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b0;
					end
					ACT_WRESET: begin
						rst0_o <= 1'b0;
						rst1_o <= 1'b1;
					end
					ACT_CRESET: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b1;
					end
					ACT_RRESET: relocated <= 1'b1;
					default: ;
				endcase
			end
			rst2_o <= is_rreset; // One pulse per RRESET.
		end
	end

	a_rst2_pulse: assert property (
		@(posedge clk_i) disable iff (rst_i)
		rst2_o |=> !rst2_o
	);

endmodule

`default_nettype wire

// File: map_size_calc.sv
// RAM map size for slot 1 of the device table.
// Whatever the devices in front of the first RAM device leave of the 4 KiB
// window is reported as the table's own map size.
`timescale 1ns/1ps
`default_nettype none

module map_size_calc (
	input  logic                                                    clk_i,
	input  logic                                                    rst_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT*soc_ctrl_pkg::DATA_W-1:0] dev_id_flat_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT*soc_ctrl_pkg::DATA_W-1:0] dev_mapsz_flat_i,
	output logic [soc_ctrl_pkg::DATA_W-1:0]                         ram_map_sz_o
);

	import soc_ctrl_pkg::*;

	logic [DATA_W-1:0] ram_sz;

	// Slots 0 and 1 are the block device and the table itself.
	always_comb begin
		logic passed_ram;
		passed_ram = 1'b0;
		ram_sz = WINDOW_SZ - BLOCK_MAP_SZ;
		for (int i = 2; i < DEV_MAP_CNT; i++) begin
			if (dev_id_flat_i[i*DATA_W +: DATA_W] == RAM_DEV_ID) begin
				passed_ram = 1'b1; // First RAM device ends the walk.
			end
			if (!passed_ram) begin
				ram_sz = ram_sz - dev_mapsz_flat_i[i*DATA_W +: DATA_W];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ram_map_sz_o <= '0;
		end else begin
			ram_map_sz_o <= ram_sz;
		end
	end

	// Devices ahead of RAM must fit in the window, else the sum wraps.
	a_sz_in_window: assert property (
		@(posedge clk_i) disable iff (rst_i)
		ram_map_sz_o <= WINDOW_SZ
	);

endmodule

`default_nettype wire

// File: pi_stage.sv
// Bus input stage of the device table.
// Registers each accepted request for one cycle and forms its byte address.
`timescale 1ns/1ps
`default_nettype none

module pi_stage (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  logic [1:0]                       op_i,
	input  logic [soc_ctrl_pkg::ADDR_W-1:0]  addr_i,
	input  logic [soc_ctrl_pkg::DATA_W-1:0]  data_i,
	input  logic [soc_ctrl_pkg::SEL_W-1:0]   sel_i,
	output logic                             rdy_o,
	output logic [1:0]                       req_op_o,
	output logic [soc_ctrl_pkg::DATA_W-1:0]  req_byte_addr_o,
	output logic [soc_ctrl_pkg::DATA_W-1:0]  req_data_o
);

	import soc_ctrl_pkg::*;

	logic              accept;
	logic [DATA_W-1:0] lane_off;
	logic [DATA_W-1:0] byte_addr;

	assign accept = rdy_o && (op_i != OP_NOP);

	// Offset of the lowest selected byte lane.
	always_comb begin
		lane_off = '0;
		for (int i = SEL_W - 1; i >= 0; i--) begin
			if (sel_i[i]) begin
				lane_off = DATA_W'(i);
			end
		end
	end

	assign byte_addr = {addr_i, {(DATA_W - ADDR_W){1'b0}}} + lane_off;

	// Control state.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdy_o <= 1'b0;
			req_op_o <= OP_NOP;
		end else begin
			rdy_o <= 1'b1; // Table never stalls.
			req_op_o <= accept ? op_i : OP_NOP;
		end
	end

	// Request payload.
	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_byte_addr_o <= byte_addr;
			req_data_o <= data_i;
		end
	end

	// A request leaving the stage had a lane selected when it was taken.
	a_req_has_sel: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(req_op_o != OP_NOP) |-> ($past(sel_i) != '0)
	);

endmodule

`default_nettype wire

// File: soc_ctrl_pkg.sv
// Shared constants and types for the SoC control block.
// Modules name widths as soc_ctrl_pkg::X in their ports and import the rest in the body.
`default_nettype none

package soc_ctrl_pkg;

	// Bus geometry.
	localparam int DATA_W = 32;
	localparam int ADDR_W = DATA_W - 2; // Word address.
	localparam int SEL_W = DATA_W / 8;

	// Device table size.
	localparam int DEV_MAP_CNT = 4;

	// Bus opcodes.
	localparam logic [1:0] OP_NOP = 2'b00;
	localparam logic [1:0] OP_WR = 2'b01;
	localparam logic [1:0] OP_RD = 2'b10;
	localparam logic [1:0] OP_RW = 2'b11;

	// Device window layout.
	localparam logic [DATA_W-1:0] WINDOW_SZ = 32'd4096;
	localparam logic [DATA_W-1:0] BLOCK_MAP_SZ = 32'd512; // Slot 0, block device.
	localparam logic [DATA_W-1:0] RAM_DEV_ID = 32'd1;

	// INFO selectors, written as data of a read-write at word 0.
	localparam logic [DATA_W-1:0] INFO_VERSION = 32'd0;
	localparam logic [DATA_W-1:0] INFO_CACHE_SZ = 32'd1;
	localparam logic [DATA_W-1:0] INFO_RST_STATE = 32'd2;
	localparam logic [DATA_W-1:0] INFO_PRELDR = 32'd3;
	localparam logic [DATA_W-1:0] INFO_SOC_ID = 32'd4;

	// ACTION codes, written as data of a read-write at word 1.
	localparam logic [DATA_W-1:0] ACT_PWROFF = 32'd0;
	localparam logic [DATA_W-1:0] ACT_WRESET = 32'd1;
	localparam logic [DATA_W-1:0] ACT_CRESET = 32'd2;
	localparam logic [DATA_W-1:0] ACT_RRESET = 32'd3;

	// Values returned by INFO queries.
	localparam logic [DATA_W-1:0] SOC_VERSION = 32'h0001_0200;
	localparam logic [DATA_W-1:0] RAM_CACHE_SZ = 32'h0000_0400; // In bus words.
	localparam logic [DATA_W-1:0] PRELDR_ADDR = 32'h0000_3000;
	localparam logic [DATA_W-1:0] SOC_ID = 32'h5C0C_0001;

	// Odd table word: map size halved, interrupt flag in the low bit.
	typedef struct packed {
		logic [DATA_W-2:0] half_sz;
		logic intr;
	} map_pair_t;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		map_pair_t pair;
	} map_word_u;

endpackage

`default_nettype wire

// File: soc_ctrl_top.sv
// Top level of the SoC control block.
// Bus stage feeds the device table; the map-size unit supplies slot 1's size.
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_top (
	input  logic                                                    clk_i,
	input  logic                                                    rst_i,
	input  logic [1:0]                                              op_i,
	input  logic [soc_ctrl_pkg::ADDR_W-1:0]                         addr_i,
	input  logic [soc_ctrl_pkg::DATA_W-1:0]                         data_i,
	input  logic [soc_ctrl_pkg::SEL_W-1:0]                          sel_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT*soc_ctrl_pkg::DATA_W-1:0] dev_id_flat_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT*soc_ctrl_pkg::DATA_W-1:0] dev_mapsz_flat_i,
	input  logic [soc_ctrl_pkg::DEV_MAP_CNT-1:0]                    dev_useintr_i,
	output logic [soc_ctrl_pkg::DATA_W-1:0]                         data_o,
	output logic                                                    rdy_o,
	output logic                                                    rst0_o,
	output logic                                                    rst1_o,
	output logic                                                    rst2_o
);

	import soc_ctrl_pkg::*;

	logic [1:0]        req_op;
	logic [DATA_W-1:0] req_byte_addr;
	logic [DATA_W-1:0] req_data;
	logic [DATA_W-1:0] ram_map_sz;

	pi_stage u_pi_stage (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.op_i            (op_i),
		.addr_i          (addr_i),
		.data_i          (data_i),
		.sel_i           (sel_i),
		.rdy_o           (rdy_o),
		.req_op_o        (req_op),
		.req_byte_addr_o (req_byte_addr),
		.req_data_o      (req_data)
	);

	map_size_calc u_map_size_calc (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.dev_id_flat_i    (dev_id_flat_i),
		.dev_mapsz_flat_i (dev_mapsz_flat_i),
		.ram_map_sz_o     (ram_map_sz)
	);

	dev_table u_dev_table (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.req_op_i         (req_op),
		.req_byte_addr_i  (req_byte_addr),
		.req_data_i       (req_data),
		.dev_id_flat_i    (dev_id_flat_i),
		.dev_mapsz_flat_i (dev_mapsz_flat_i),
		.dev_useintr_i    (dev_useintr_i),
		.ram_map_sz_i     (ram_map_sz),
		.rd_data_o        (data_o),
		.rst0_o           (rst0_o),
		.rst1_o           (rst1_o),
		.rst2_o           (rst2_o)
	);

endmodule

`default_nettype wire

// File: soc_ctrl_trace.txt
// op addr data sel | id0 id1 id2 id3 | sz0 sz1 sz2 sz3 | intr | exp_data exp_rst0 exp_rst1
// All fields hex, one bus operation per line; an op of ff ends the trace.
// Table reads, RAM in slot 3.
2 0 0 f  3 10 2 1  200 0 100 800  5  3 0 0
2 1 0 f  3 10 2 1  200 0 100 800  5  201 0 0
2 2 0 1  3 10 2 1  200 0 100 800  5  10 0 0
2 3 0 f  3 10 2 1  200 0 100 800  5  d00 0 0
2 4 0 4  3 10 2 1  200 0 100 800  5  2 0 0
2 5 0 f  3 10 2 1  200 0 100 800  5  101 0 0
2 6 0 f  3 10 2 1  200 0 100 800  5  1 0 0
2 7 0 8  3 10 2 1  200 0 100 800  5  800 0 0
1 7 0 f  3 10 2 1  200 0 100 800  5  800 0 0
0 0 0 0  3 10 2 1  200 0 100 800  5  800 0 0
2 8 0 f  3 10 2 1  200 0 100 800  5  0 0 0
2 9 0 2  3 10 2 1  200 0 100 800  5  0 0 0
// INFO queries.
3 0 0 f  3 10 2 1  200 0 100 800  5  10200 0 0
3 0 1 f  3 10 2 1  200 0 100 800  5  400 0 0
3 0 3 f  3 10 2 1  200 0 100 800  5  3000 0 0
3 0 4 f  3 10 2 1  200 0 100 800  5  5c0c0001 0 0
3 0 7 f  3 10 2 1  200 0 100 800  5  0 0 0
3 0 2 f  3 10 2 1  200 0 100 800  5  0 0 0
// ACTION commands and reset state read-back.
3 1 0 f  3 10 2 1  200 0 100 800  5  0 1 0
3 0 2 f  3 10 2 1  200 0 100 800  5  1 1 0
1 1 0 f  3 10 2 1  200 0 100 800  5  1 1 0
3 1 1 f  3 10 2 1  200 0 100 800  5  0 0 1
3 0 2 f  3 10 2 1  200 0 100 800  5  2 0 1
0 0 0 0  3 10 2 1  200 0 100 800  5  2 0 1
3 1 2 f  3 10 2 1  200 0 100 800  5  0 1 1
3 0 2 f  3 10 2 1  200 0 100 800  5  3 1 1
1 0 0 f  3 10 2 1  200 0 100 800  5  3 1 1
3 1 9 f  3 10 2 1  200 0 100 800  5  0 1 1
3 0 2 f  3 10 2 1  200 0 100 800  5  3 1 1
3 2 0 f  3 10 2 1  200 0 100 800  5  0 1 1
3 0 3 f  3 10 2 1  200 0 100 800  5  3000 1 1
3 1 3 f  3 10 2 1  200 0 100 800  5  0 1 1
3 0 3 f  3 10 2 1  200 0 100 800  5  0 1 1
3 0 0 f  3 10 2 1  200 0 100 800  5  10200 1 1
// RAM moved to slot 2.
2 3 0 f  3 10 1 2  200 0 800 100  6  e01 1 1
2 4 0 f  3 10 1 2  200 0 800 100  6  1 1 1
2 5 0 f  3 10 1 2  200 0 800 100  6  801 1 1
2 1 0 f  3 10 1 2  200 0 800 100  6  200 1 1
2 6 0 f  3 10 1 2  200 0 800 100  6  2 1 1
// No RAM device at all.
2 3 0 f  3 10 2 4  200 0 100 300  0  a00 1 1
2 7 0 f  3 10 2 4  200 0 100 300  0  300 1 1
ff

// File: sources.f
soc_ctrl_pkg.sv
pi_stage.sv
map_size_calc.sv
dev_table.sv
soc_ctrl_top.sv
tb_soc_ctrl.sv

// File: tb_soc_ctrl.sv
// Self-checking testbench for the SoC control block.
// Replays soc_ctrl_trace.txt, one bus operation per record, and checks data_o,
// the reset outputs and the slot-1 map size against the expected values.
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ctrl;

	import soc_ctrl_pkg::*;

	localparam string TRACE_FILE = "soc_ctrl_trace.txt";
	localparam int FIELDS = 4 + 2 * DEV_MAP_CNT + 4; // Words per trace record.
	localparam int TRACE_MAX = 64;
	localparam int F_OP = 0;
	localparam int F_ADDR = 1;
	localparam int F_DATA = 2;
	localparam int F_SEL = 3;
	localparam int F_ID = 4;
	localparam int F_SZ = F_ID + DEV_MAP_CNT;
	localparam int F_INTR = F_SZ + DEV_MAP_CNT;
	localparam int F_EXP_DATA = F_INTR + 1;
	localparam int F_EXP_RST0 = F_INTR + 2;
	localparam int F_EXP_RST1 = F_INTR + 3;

	logic                          clk_i;
	logic                          rst_i;
	logic [1:0]                    op_i;
	logic [ADDR_W-1:0]             addr_i;
	logic [DATA_W-1:0]             data_i;
	logic [SEL_W-1:0]              sel_i;
	logic [DEV_MAP_CNT*DATA_W-1:0] dev_id_flat_i;
	logic [DEV_MAP_CNT*DATA_W-1:0] dev_mapsz_flat_i;
	logic [DEV_MAP_CNT-1:0]        dev_useintr_i;
	logic [DATA_W-1:0]             data_o;
	logic                          rdy_o;
	logic                          rst0_o;
	logic                          rst1_o;
	logic                          rst2_o;

	logic [DATA_W-1:0] trace_mem [0:TRACE_MAX*FIELDS-1];
	int                n_ops = 0;
	int                error_cnt = 0;
	int                check_cnt = 0;
	int                cycle_cnt = 0;
	int                cycle_limit = 0; // Zero until the trace is loaded.
	logic [31:0]       rnd_state = 32'd15;

	soc_ctrl_top UUT (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.op_i             (op_i),
		.addr_i           (addr_i),
		.data_i           (data_i),
		.sel_i            (sel_i),
		.dev_id_flat_i    (dev_id_flat_i),
		.dev_mapsz_flat_i (dev_mapsz_flat_i),
		.dev_useintr_i    (dev_useintr_i),
		.data_o           (data_o),
		.rdy_o            (rdy_o),
		.rst0_o           (rst0_o),
		.rst1_o           (rst1_o),
		.rst2_o           (rst2_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i; // 100 ns period.
	end

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("Checks: %0d, errors: %0d.", check_cnt, error_cnt);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Window left over after slot 0 and the devices ahead of the first RAM device.
	function automatic logic [DATA_W-1:0] expected_ram_size(
		input logic [DEV_MAP_CNT*DATA_W-1:0] ids,
		input logic [DEV_MAP_CNT*DATA_W-1:0] sizes
	);
		logic [DATA_W-1:0] left;
		int                s;
		left = 32'd3584;
		s = 2;
		while (s < DEV_MAP_CNT && ids[s*DATA_W +: DATA_W] != RAM_DEV_ID) begin
			left = left - sizes[s*DATA_W +: DATA_W];
			s++;
		end
		return left;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic load_trace(output bit ok);
		int fd;
		ok = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("The trace file %s could not be opened.", TRACE_FILE);
			return;
		end
		$fclose(fd);
		$readmemh(TRACE_FILE, trace_mem);
		while (n_ops < TRACE_MAX && trace_mem[n_ops*FIELDS+F_OP] !== 32'hff
				&& !$isunknown(trace_mem[n_ops*FIELDS+F_OP])) begin
			n_ops++;
		end
		ok = (n_ops > 0) && (n_ops < TRACE_MAX) && (trace_mem[n_ops*FIELDS+F_OP] === 32'hff);
		if (!ok) begin
			$display("The trace file holds no operations or lacks its end marker.");
		end
	endtask

	// Drives one record, follows it with a no-op and checks two edges later.
	task automatic run_op(input int idx);
		int                base;
		logic              exp_rst2;
		logic [DATA_W-1:0] ram_sz;
		base = idx * FIELDS;
		op_i = trace_mem[base+F_OP][1:0];
		addr_i = trace_mem[base+F_ADDR][ADDR_W-1:0];
		data_i = trace_mem[base+F_DATA];
		sel_i = trace_mem[base+F_SEL][SEL_W-1:0];
		if (op_i == OP_WR) begin
			rnd_state = xorshift32(rnd_state);
			data_i = rnd_state; // Write data is ignored by the table.
		end
		for (int s = 0; s < DEV_MAP_CNT; s++) begin
			dev_id_flat_i[s*DATA_W +: DATA_W] = trace_mem[base+F_ID+s];
			dev_mapsz_flat_i[s*DATA_W +: DATA_W] = trace_mem[base+F_SZ+s];
		end
		dev_useintr_i = trace_mem[base+F_INTR][DEV_MAP_CNT-1:0];
		exp_rst2 = (op_i == OP_RW) && (addr_i == 1) && (data_i == ACT_RRESET);
		@(negedge clk_i);
		op_i = OP_NOP;
		@(negedge clk_i);
		check($sformatf("op %0d data_o", idx), data_o, trace_mem[base+F_EXP_DATA]);
		check($sformatf("op %0d rst0_o", idx), rst0_o, trace_mem[base+F_EXP_RST0][0]);
		check($sformatf("op %0d rst1_o", idx), rst1_o, trace_mem[base+F_EXP_RST1][0]);
		check($sformatf("op %0d rst2_o", idx), rst2_o, exp_rst2);
		check($sformatf("op %0d rdy_o", idx), rdy_o, 1'b1);
		if (trace_mem[base+F_OP][1:0] == OP_RD && trace_mem[base+F_ADDR] == 3) begin
			ram_sz = expected_ram_size(dev_id_flat_i, dev_mapsz_flat_i);
			check($sformatf("op %0d slot-1 map size", idx), data_o,
				{ram_sz[DATA_W-1:1], dev_useintr_i[1]});
		end
		@(negedge clk_i);
		check($sformatf("op %0d rst2_o after pulse", idx), rst2_o, 1'b0);
	endtask

	initial begin
		bit trace_ok;
		rst_i = 1'b1;
		op_i = OP_NOP;
		addr_i = '0;
		data_i = '0;
		sel_i = '0;
		dev_id_flat_i = '0;
		dev_mapsz_flat_i = '0;
		dev_useintr_i = '0;
		load_trace(trace_ok);
		if (!trace_ok) begin
			error_cnt++;
		end else begin
			cycle_limit = 3 * n_ops + 20;
			repeat (3) @(posedge clk_i);
			@(negedge clk_i);
			check("rdy_o in reset", rdy_o, 1'b0);
			rst_i = 1'b0;
			@(negedge clk_i);
			check("rdy_o after reset", rdy_o, 1'b1);
			check("data_o after reset", data_o, '0);
			check("rst0_o after reset", rst0_o, 1'b0);
			check("rst1_o after reset", rst1_o, 1'b0);
			check("rst2_o after reset", rst2_o, 1'b0);
			for (int i = 0; i < n_ops; i++) begin
				run_op(i);
			end
		end
		$display("Checks: %0d, errors: %0d.", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
